// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= llc_tb
FILELIST  ?= llc_set.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== llc_set.f ====
verilog/llc_pkg.sv
verilog/llc_set_mem.sv
verilog/llc_set_bufs.sv
verilog/llc_lookup.sv
verilog/llc_ctrl.sv
verilog/llc_top.sv
test/llc_tb_sva.sv
test/llc_tb.sv

// ==== test/llc_tb.sv ====
// ****************************
// LLC testbench
// ****************************
`timescale 1ns/1ps
`default_nettype none

module llc_tb;

    localparam int WAYS        = 4;
    localparam int SET_BITS    = 3;
    localparam int SETS        = 1 << SET_BITS;
    localparam int ADDR_BITS   = llc_pkg::ADDR_BITS;
    localparam int OFFSET_BITS = llc_pkg::OFFSET_BITS;
    localparam int TAG_BITS    = ADDR_BITS - SET_BITS - OFFSET_BITS;
    localparam int WB          = llc_pkg::WORD_BITS;
    localparam int N_REQ       = 2000;
    localparam int PERIOD      = 4;
    // Dirty miss with the longest fetch latency, plus the idle cycle.
    localparam int REQ_CYCLES  = 24;
    localparam int LIMIT_NS    = N_REQ * REQ_CYCLES * PERIOD + 20 * PERIOD;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    llc_pkg::core_op_t     req_op;
    logic [ADDR_BITS-1:0]  req_addr;
    llc_pkg::word_t        req_wdata;
    logic                  mem_rsp_valid;
    llc_pkg::line_t        mem_rsp_line;
    logic                  busy;
    logic                  rsp_valid;
    llc_pkg::word_t        rsp_rdata;
    logic                  mem_req_valid;
    llc_pkg::mem_op_t      mem_req_op;
    logic [ADDR_BITS-1:0]  mem_req_addr;
    llc_pkg::line_t        mem_req_line;

    logic [31:0]           seed;
    llc_pkg::line_t        mem_model [int];
    llc_pkg::word_t        written [int];
    logic [TAG_BITS-1:0]   m_tag [SETS][WAYS];
    logic                  m_valid [SETS][WAYS];
    logic                  m_dirty [SETS][WAYS];
    int                    m_ptr [SETS];

    llc_top #(.WAYS(WAYS), .SET_BITS(SET_BITS)) i_dut (.*);

    always #(PERIOD / 2) clk = ~clk;

    function logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {16'h0000, seed[31:16]};
    endfunction

    // Memory contents of a word that was never written.
    function automatic llc_pkg::word_t fill_word(input int word_addr);
        logic [15:0] a;
        a = word_addr[15:0];
        return {~a, a};
    endfunction

    function automatic llc_pkg::word_t current_word(input int word_addr);
        return written.exists(word_addr) ? written[word_addr] : fill_word(word_addr);
    endfunction

    function automatic llc_pkg::line_t victim_contents(input int line_addr);
        llc_pkg::line_t l;
        for (int i = 0; i < llc_pkg::LINE_WORDS; i++) begin
            l[i*WB +: WB] = current_word(line_addr * llc_pkg::LINE_WORDS + i);
        end
        return l;
    endfunction

    function automatic llc_pkg::line_t memory_line(input int line_addr);
        llc_pkg::line_t l;
        if (mem_model.exists(line_addr)) begin
            return mem_model[line_addr];
        end
        for (int i = 0; i < llc_pkg::LINE_WORDS; i++) begin
            l[i*WB +: WB] = fill_word(line_addr * llc_pkg::LINE_WORDS + i);
        end
        return l;
    endfunction

    task automatic check_eq(input logic [127:0] got, input logic [127:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic run_request(input llc_pkg::core_op_t op, input logic [ADDR_BITS-1:0] addr,
                               input llc_pkg::word_t wdata);
        logic [SET_BITS-1:0]  st;
        logic [TAG_BITS-1:0]  tg;
        logic [ADDR_BITS-1:0] wb_addr;
        int                   s;
        int                   v;
        int                   n_exp;
        int                   n_mem;
        int                   cyc;
        int                   wait_left;
        int                   fetch_la;
        bit                   hit;
        bit                   from_ptr;
        bit                   done;
        st = addr[OFFSET_BITS +: SET_BITS];
        tg = addr[ADDR_BITS-1 -: TAG_BITS];
        s = int'(st);
        v = -1;
        hit = 1'b0;
        from_ptr = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == tg) begin
                hit = 1'b1;
                v = w;
            end
        end
        // Victim is the first empty way, else the set's round-robin pointer.
        for (int w = 0; w < WAYS; w++) begin
            if (!hit && v < 0 && !m_valid[s][w]) begin
                v = w;
            end
        end
        if (v < 0) begin
            v = m_ptr[s];
            from_ptr = 1'b1;
        end
        wb_addr = {m_tag[s][v], st, {OFFSET_BITS{1'b0}}};
        n_exp = hit ? 0 : ((from_ptr && m_dirty[s][v]) ? 2 : 1);

        @(posedge clk);
        req_valid <= 1'b1;
        req_op    <= op;
        req_addr  <= addr;
        req_wdata <= wdata;
        cyc = 0;
        n_mem = 0;
        wait_left = 0;
        fetch_la = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (mem_req_valid) begin
                check_eq(128'(n_mem < n_exp), 128'(1), "memory request count exceeded");
                if (n_mem == 0 && n_exp == 2) begin
                    check_eq(128'(mem_req_op), 128'(llc_pkg::MEM_WRITEBACK), "write-back op");
                    check_eq(128'(mem_req_addr), 128'(wb_addr), "write-back address");
                    check_eq(mem_req_line, victim_contents(int'(wb_addr[ADDR_BITS-1:2])),
                             "write-back line");
                    mem_model[int'(wb_addr[ADDR_BITS-1:2])] = mem_req_line;
                end else begin
                    check_eq(128'(mem_req_op), 128'(llc_pkg::MEM_FETCH), "fetch op");
                    check_eq(128'(mem_req_addr), 128'({tg, st, {OFFSET_BITS{1'b0}}}),
                             "fetch address");
                    fetch_la = int'(addr[ADDR_BITS-1:2]);
                    wait_left = 1 + int'(next_rand() % 32'd8);
                end
                n_mem++;
            end
            if (rsp_valid) begin
                done = 1'b1;
                if (hit) begin
                    check_eq(128'(cyc), 128'(4), "hit latency");
                end
                if (op == llc_pkg::OP_READ) begin
                    check_eq(128'(rsp_rdata), 128'(current_word(int'(addr))), "read data");
                end
            end
            cyc++;
            @(posedge clk);
            req_valid     <= 1'b0;
            mem_rsp_valid <= 1'b0;
            if (wait_left > 0) begin
                wait_left--;
                if (wait_left == 0) begin
                    mem_rsp_valid <= 1'b1;
                    mem_rsp_line  <= memory_line(fetch_la);
                end
            end
        end
        check_eq(128'(n_mem), 128'(n_exp), "memory requests per access");

        if (!hit) begin
            m_tag[s][v]   = tg;
            m_valid[s][v] = 1'b1;
            m_dirty[s][v] = 1'b0;
            if (from_ptr) begin
                m_ptr[s] = (m_ptr[s] + 1) % WAYS;
            end
        end
        if (op == llc_pkg::OP_WRITE) begin
            m_dirty[s][v] = 1'b1;
            written[int'(addr)] = wdata;
        end
    endtask

    initial begin
        #(LIMIT_NS);
        $display("Timeout: run still going after %0d ns", LIMIT_NS);
        $display("*** FAILED ***");
        $fatal(1);
    end

    initial begin
        logic [TAG_BITS-1:0] tg;
        logic [SET_BITS-1:0] st;
        logic [1:0]          off;
        logic [31:0]         hi;
        llc_pkg::core_op_t   op;
        clk           = 1'b0;
        rst           = 1'b0;
        req_valid     = 1'b0;
        req_op        = llc_pkg::OP_READ;
        req_addr      = '0;
        req_wdata     = '0;
        mem_rsp_valid = 1'b0;
        mem_rsp_line  = '0;
        seed          = 32'he1ef;
        for (int s = 0; s < SETS; s++) begin
            m_ptr[s] = 0;
            for (int w = 0; w < WAYS; w++) begin
                m_tag[s][w]   = '0;
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end
        repeat (10) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_eq(128'(busy), 128'(0), "busy after reset");
        check_eq(128'(rsp_valid), 128'(0), "rsp_valid after reset");
        check_eq(128'(mem_req_valid), 128'(0), "mem_req_valid after reset");

        // Six tags per set over four ways keeps the sets under pressure.
        for (int n = 0; n < N_REQ; n++) begin
            op  = (next_rand() % 32'd2 == 0) ? llc_pkg::OP_READ : llc_pkg::OP_WRITE;
            tg  = TAG_BITS'((next_rand() % 32'd6) * 32'd37);
            st  = SET_BITS'(next_rand());
            off = 2'(next_rand());
            hi  = next_rand();
            run_request(op, {tg, st, off}, (hi << 16) | next_rand());
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/llc_tb_sva.sv ====
// ****************************
// LLC port assertions
// ****************************
`timescale 1ns/1ps
`default_nettype none

module llc_tb_sva (
    input logic             clk,
    input logic             rst,
    input logic             req_valid,
    input logic             busy,
    input logic             rsp_valid,
    input logic             mem_req_valid,
    input llc_pkg::mem_op_t mem_req_op,
    input logic             mem_rsp_valid
);

    logic fetch_open;

    // Fetch issued and not yet answered.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fetch_open <= 1'b0;
        end else if (mem_rsp_valid) begin
            fetch_open <= 1'b0;
        end else if (mem_req_valid && mem_req_op == llc_pkg::MEM_FETCH) begin
            fetch_open <= 1'b1;
        end
    end

    a_rsp_pulse: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid |=> !rsp_valid) else $error("rsp_valid held longer than one cycle");

    a_mem_pulse: assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid |=> !mem_req_valid) else $error("mem_req_valid held longer than one cycle");

    a_busy_rise: assert property (@(posedge clk) disable iff (!rst)
        req_valid |=> busy) else $error("busy did not rise after req_valid");

    a_busy_hold: assert property (@(posedge clk) disable iff (!rst)
        busy && !rsp_valid |=> busy) else $error("busy dropped before rsp_valid");

    a_busy_fall: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid |=> !busy) else $error("busy still high after rsp_valid");

    a_rsp_owed: assert property (@(posedge clk) disable iff (!rst)
        mem_rsp_valid |-> fetch_open) else $error("memory response without a fetch");

endmodule

bind llc_top llc_tb_sva i_sva (.*);

`default_nettype wire

// ==== verilog/llc_ctrl.sv ====
// ****************************
// LLC request controller
// ****************************
`timescale 1ns/1ps
`default_nettype none

module llc_ctrl #(
    parameter int WAYS        = 4,
    parameter int SET_BITS    = 3,
    localparam int TAG_BITS   = llc_pkg::ADDR_BITS - SET_BITS - llc_pkg::OFFSET_BITS,
    localparam int WAY_BITS   = $clog2(WAYS)
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    input  llc_pkg::core_op_t             req_op,
    input  logic [llc_pkg::ADDR_BITS-1:0] req_addr,
    input  llc_pkg::word_t                req_wdata,
    input  logic                          hit,
    input  logic [WAY_BITS-1:0]           hit_way,
    input  logic [WAY_BITS-1:0]           victim_way,
    input  logic                          victim_from_ptr,
    input  llc_pkg::line_t                lines_buf [WAYS],
    input  logic [TAG_BITS-1:0]           tags_buf [WAYS],
    input  logic                          dirty_bits_buf [WAYS],
    input  logic                          mem_rsp_valid,
    output logic                          busy,
    output logic                          rsp_valid,
    output llc_pkg::word_t                rsp_rdata,
    output logic                          mem_req_valid,
    output llc_pkg::mem_op_t              mem_req_op,
    output logic [llc_pkg::ADDR_BITS-1:0] mem_req_addr,
    output llc_pkg::line_t                mem_req_line,
    output logic [SET_BITS-1:0]           set_idx,
    output logic [TAG_BITS-1:0]           tag,
    output logic                          rd_mem_en,
    output logic                          look,
    output logic                          rst_state,
    output logic                          rsp_load,
    output logic [WAY_BITS-1:0]           way,
    output logic                          wr_en_lines_buf,
    output llc_pkg::line_t                lines_buf_wr_data,
    output logic                          wr_en_tags_buf,
    output logic [TAG_BITS-1:0]           tags_buf_wr_data,
    output logic                          wr_en_states_buf,
    output llc_pkg::llc_state_t           states_buf_wr_data,
    output logic                          wr_en_dirty_bits_buf,
    output logic                          dirty_bits_buf_wr_data,
    output logic                          incr_evict_way_buf,
    output logic                          wr_set
);

    localparam int WB = llc_pkg::WORD_BITS;

    llc_pkg::ctrl_state_t            state;
    llc_pkg::core_op_t               op_r;
    logic [llc_pkg::ADDR_BITS-1:0]   addr_r;
    llc_pkg::word_t                  wdata_r;
    logic [WAY_BITS-1:0]             way_r;
    logic                            hit_r;
    logic                            from_ptr_r;
    logic                            wb_sent;
    logic [llc_pkg::OFFSET_BITS-1:0] offset;
    llc_pkg::line_t                  line_sel;
    logic                            is_write;

    assign offset   = addr_r[llc_pkg::OFFSET_BITS-1:0];
    assign set_idx  = addr_r[llc_pkg::OFFSET_BITS +: SET_BITS];
    assign tag      = addr_r[llc_pkg::ADDR_BITS-1 -: TAG_BITS];
    assign line_sel = lines_buf[way_r];
    assign is_write = (op_r == llc_pkg::OP_WRITE);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= llc_pkg::S_IDLE;
            hit_r      <= 1'b0;
            from_ptr_r <= 1'b0;
            wb_sent    <= 1'b0;
        end else begin
            case (state)
                llc_pkg::S_IDLE: if (req_valid) state <= llc_pkg::S_LOOK;
                llc_pkg::S_LOOK: state <= llc_pkg::S_CHECK;
                llc_pkg::S_CHECK: begin
                    hit_r      <= hit;
                    from_ptr_r <= !hit && victim_from_ptr;
                    // Only a pointer victim can be valid, hence possibly dirty.
                    if (hit) begin
                        state <= llc_pkg::S_UPDATE;
                    end else if (victim_from_ptr && dirty_bits_buf[victim_way]) begin
                        state <= llc_pkg::S_EVICT;
                    end else begin
                        state <= llc_pkg::S_FETCH;
                    end
                end
                llc_pkg::S_EVICT: begin
                    wb_sent <= 1'b1;
                    state   <= llc_pkg::S_FETCH;
                end
                llc_pkg::S_FETCH: begin
                    // One quiet cycle after a write-back keeps the strobes apart.
                    if (wb_sent) begin
                        wb_sent <= 1'b0;
                    end else begin
                        state <= llc_pkg::S_WAIT;
                    end
                end
                llc_pkg::S_WAIT: if (mem_rsp_valid) state <= llc_pkg::S_UPDATE;
                llc_pkg::S_UPDATE: state <= llc_pkg::S_STORE;
                default: state <= llc_pkg::S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == llc_pkg::S_IDLE && req_valid) begin
            op_r    <= req_op;
            addr_r  <= req_addr;
            wdata_r <= req_wdata;
        end
        if (state == llc_pkg::S_CHECK) begin
            way_r <= hit ? hit_way : victim_way;
        end
    end

    assign busy      = (state != llc_pkg::S_IDLE);
    assign rsp_valid = (state == llc_pkg::S_STORE);
    assign rst_state = (state == llc_pkg::S_STORE);
    assign wr_set    = (state == llc_pkg::S_STORE);
    assign rsp_rdata = line_sel[offset*WB +: WB];
    assign rd_mem_en = (state == llc_pkg::S_LOOK);
    assign look      = (state == llc_pkg::S_LOOK);
    assign rsp_load  = (state == llc_pkg::S_WAIT) && mem_rsp_valid;
    assign way       = way_r;

    assign mem_req_valid = (state == llc_pkg::S_EVICT) || (state == llc_pkg::S_FETCH && !wb_sent);
    assign mem_req_op    = (state == llc_pkg::S_EVICT) ? llc_pkg::MEM_WRITEBACK : llc_pkg::MEM_FETCH;
    assign mem_req_addr  = (state == llc_pkg::S_EVICT) ?
                           {tags_buf[way_r], set_idx, {llc_pkg::OFFSET_BITS{1'b0}}} :
                           {tag, set_idx, {llc_pkg::OFFSET_BITS{1'b0}}};
    assign mem_req_line  = line_sel;

    always_comb begin
        lines_buf_wr_data = line_sel;
        lines_buf_wr_data[offset*WB +: WB] = wdata_r;
    end

    assign wr_en_lines_buf    = (state == llc_pkg::S_UPDATE) && is_write;
    assign wr_en_tags_buf     = (state == llc_pkg::S_UPDATE);
    assign tags_buf_wr_data   = tag;
    assign wr_en_states_buf   = (state == llc_pkg::S_UPDATE);
    assign states_buf_wr_data = llc_pkg::VALID;
    // Read hits keep their dirty bit, fills start clean.
    assign wr_en_dirty_bits_buf   = (state == llc_pkg::S_UPDATE) && (is_write || !hit_r);
    assign dirty_bits_buf_wr_data = is_write;
    assign incr_evict_way_buf     = (state == llc_pkg::S_UPDATE) && from_ptr_r;

endmodule

`default_nettype wire

// ==== verilog/llc_lookup.sv ====
// ****************************
// LLC tag lookup
// ****************************
`timescale 1ns/1ps
`default_nettype none

module llc_lookup #(
    parameter int WAYS        = 4,
    parameter int SET_BITS    = 3,
    localparam int TAG_BITS   = llc_pkg::ADDR_BITS - SET_BITS - llc_pkg::OFFSET_BITS,
    localparam int WAY_BITS   = $clog2(WAYS)
) (
    input  logic [TAG_BITS-1:0] tag,
    input  logic [TAG_BITS-1:0] tags_buf [WAYS],
    input  llc_pkg::llc_state_t states_buf [WAYS],
    input  logic [WAY_BITS-1:0] evict_way_buf,
    output logic                hit,
    output logic [WAY_BITS-1:0] hit_way,
    output logic [WAY_BITS-1:0] victim_way,
    output logic                victim_from_ptr
);

    always_comb begin
        hit             = 1'b0;
        hit_way         = '0;
        victim_way      = evict_way_buf;
        victim_from_ptr = 1'b1;
        // Downward scan, so the lowest invalid way ends up as victim.
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (states_buf[i] == llc_pkg::VALID) begin
                if (tags_buf[i] == tag) begin
                    hit     = 1'b1;
                    hit_way = WAY_BITS'(i);
                end
            end else begin
                victim_way      = WAY_BITS'(i);
                victim_from_ptr = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/llc_pkg.sv ====
// ****************************
// LLC shared definitions
// ****************************
`default_nettype none

package llc_pkg;

    localparam int WORD_BITS   = 32;
    localparam int LINE_WORDS  = 4;
    localparam int OFFSET_BITS = 2;
    localparam int ADDR_BITS   = 16;

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [LINE_WORDS*WORD_BITS-1:0] line_t;

    typedef enum logic {
        INVALID = 1'b0,
        VALID   = 1'b1
    } llc_state_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } core_op_t;

    typedef enum logic {
        MEM_FETCH     = 1'b0,
        MEM_WRITEBACK = 1'b1
    } mem_op_t;

    // Controller states.
    typedef enum logic [2:0] {
        S_IDLE, S_LOOK, S_CHECK, S_EVICT, S_FETCH, S_WAIT, S_UPDATE, S_STORE
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== verilog/llc_set_bufs.sv ====
// ****************************
// LLC set buffer
// ****************************
`timescale 1ns/1ps
`default_nettype none

module llc_set_bufs #(
    parameter int WAYS        = 4,
    parameter int SET_BITS    = 3,
    localparam int TAG_BITS   = llc_pkg::ADDR_BITS - SET_BITS - llc_pkg::OFFSET_BITS,
    localparam int WAY_BITS   = $clog2(WAYS)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                rst_state,
    input  logic                rd_mem_en,
    input  logic                look,
    input  logic                incr_evict_way_buf,
    input  logic                rsp_load,
    input  llc_pkg::line_t      mem_rsp_line,
    input  logic [WAY_BITS-1:0] way,
    input  logic                wr_en_lines_buf,
    input  logic                wr_en_tags_buf,
    input  logic                wr_en_states_buf,
    input  logic                wr_en_dirty_bits_buf,
    input  llc_pkg::line_t      lines_buf_wr_data,
    input  logic [TAG_BITS-1:0] tags_buf_wr_data,
    input  llc_pkg::llc_state_t states_buf_wr_data,
    input  logic                dirty_bits_buf_wr_data,
    input  llc_pkg::line_t      rd_lines [WAYS],
    input  logic [TAG_BITS-1:0] rd_tags [WAYS],
    input  llc_pkg::llc_state_t rd_states [WAYS],
    input  logic                rd_dirty [WAYS],
    input  logic [WAY_BITS-1:0] rd_evict_way,
    output llc_pkg::line_t      lines_buf [WAYS],
    output logic [TAG_BITS-1:0] tags_buf [WAYS],
    output llc_pkg::llc_state_t states_buf [WAYS],
    output logic                dirty_bits_buf [WAYS],
    output logic [WAY_BITS-1:0] evict_way_buf
);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            evict_way_buf <= '0;
        end else if (rst_state) begin
            evict_way_buf <= '0;
        end else if (rd_mem_en && look) begin
            evict_way_buf <= rd_evict_way;
        end else if (incr_evict_way_buf) begin
            evict_way_buf <= evict_way_buf + 1'b1;
        end
    end

    // Lines also take the fetched line into the selected way.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < WAYS; i++) begin
                lines_buf[i] <= '0;
            end
        end else begin
            for (int i = 0; i < WAYS; i++) begin
                if (rst_state) begin
                    lines_buf[i] <= '0;
                end else if (rd_mem_en && look) begin
                    lines_buf[i] <= rd_lines[i];
                end else if (rsp_load && way == WAY_BITS'(i)) begin
                    lines_buf[i] <= mem_rsp_line;
                end else if (wr_en_lines_buf && way == WAY_BITS'(i)) begin
                    lines_buf[i] <= lines_buf_wr_data;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < WAYS; i++) begin
                tags_buf[i]       <= '0;
                states_buf[i]     <= llc_pkg::INVALID;
                dirty_bits_buf[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < WAYS; i++) begin
                if (rst_state) begin
                    tags_buf[i]       <= '0;
                    states_buf[i]     <= llc_pkg::INVALID;
                    dirty_bits_buf[i] <= 1'b0;
                end else if (rd_mem_en && look) begin
                    tags_buf[i]       <= rd_tags[i];
                    states_buf[i]     <= rd_states[i];
                    dirty_bits_buf[i] <= rd_dirty[i];
                end else begin
                    if (wr_en_tags_buf && way == WAY_BITS'(i)) begin
                        tags_buf[i] <= tags_buf_wr_data;
                    end
                    if (wr_en_states_buf && way == WAY_BITS'(i)) begin
                        states_buf[i] <= states_buf_wr_data;
                    end
                    if (wr_en_dirty_bits_buf && way == WAY_BITS'(i)) begin
                        dirty_bits_buf[i] <= dirty_bits_buf_wr_data;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/llc_set_mem.sv ====
// ****************************
// LLC set array
// ****************************
`timescale 1ns/1ps
`default_nettype none

module llc_set_mem #(
    parameter int WAYS        = 4,
    parameter int SET_BITS    = 3,
    localparam int TAG_BITS   = llc_pkg::ADDR_BITS - SET_BITS - llc_pkg::OFFSET_BITS,
    localparam int WAY_BITS   = $clog2(WAYS)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [SET_BITS-1:0] set_idx,
    input  logic                wr_set,
    input  llc_pkg::line_t      lines_in [WAYS],
    input  logic [TAG_BITS-1:0] tags_in [WAYS],
    input  llc_pkg::llc_state_t states_in [WAYS],
    input  logic                dirty_in [WAYS],
    input  logic [WAY_BITS-1:0] evict_way_in,
    output llc_pkg::line_t      rd_lines [WAYS],
    output logic [TAG_BITS-1:0] rd_tags [WAYS],
    output llc_pkg::llc_state_t rd_states [WAYS],
    output logic                rd_dirty [WAYS],
    output logic [WAY_BITS-1:0] rd_evict_way
);

    localparam int SETS = 1 << SET_BITS;

    llc_pkg::line_t      lines_q  [SETS][WAYS];
    logic [TAG_BITS-1:0] tags_q   [SETS][WAYS];
    llc_pkg::llc_state_t states_q [SETS][WAYS];
    logic                dirty_q  [SETS][WAYS];
    logic [WAY_BITS-1:0] evict_q  [SETS];

    // Line data and tags.
    always_ff @(posedge clk) begin
        if (wr_set) begin
            for (int w = 0; w < WAYS; w++) begin
                lines_q[set_idx][w] <= lines_in[w];
                tags_q[set_idx][w]  <= tags_in[w];
            end
        end
    end

    // State, dirty bits and the eviction pointer of each set.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                evict_q[s] <= '0;
                for (int w = 0; w < WAYS; w++) begin
                    states_q[s][w] <= llc_pkg::INVALID;
                    dirty_q[s][w]  <= 1'b0;
                end
            end
        end else if (wr_set) begin
            evict_q[set_idx] <= evict_way_in;
            for (int w = 0; w < WAYS; w++) begin
                states_q[set_idx][w] <= states_in[w];
                dirty_q[set_idx][w]  <= dirty_in[w];
            end
        end
    end

    // Indexed set, read straight from the registers.
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            rd_lines[w]  = lines_q[set_idx][w];
            rd_tags[w]   = tags_q[set_idx][w];
            rd_states[w] = states_q[set_idx][w];
            rd_dirty[w]  = dirty_q[set_idx][w];
        end
        rd_evict_way = evict_q[set_idx];
    end

endmodule

`default_nettype wire

// ==== verilog/llc_top.sv ====
// ****************************
// LLC top level
// ****************************
`timescale 1ns/1ps
`default_nettype none

module llc_top #(
    parameter int WAYS     = 4,
    parameter int SET_BITS = 3
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    input  llc_pkg::core_op_t             req_op,
    input  logic [llc_pkg::ADDR_BITS-1:0] req_addr,
    input  llc_pkg::word_t                req_wdata,
    input  logic                          mem_rsp_valid,
    input  llc_pkg::line_t                mem_rsp_line,
    output logic                          busy,
    output logic                          rsp_valid,
    output llc_pkg::word_t                rsp_rdata,
    output logic                          mem_req_valid,
    output llc_pkg::mem_op_t              mem_req_op,
    output logic [llc_pkg::ADDR_BITS-1:0] mem_req_addr,
    output llc_pkg::line_t                mem_req_line
);

    localparam int TAG_BITS = llc_pkg::ADDR_BITS - SET_BITS - llc_pkg::OFFSET_BITS;
    localparam int WAY_BITS = $clog2(WAYS);

    logic [SET_BITS-1:0] set_idx;
    logic [TAG_BITS-1:0] tag;
    logic [WAY_BITS-1:0] way, rd_evict_way, evict_way_buf, hit_way, victim_way;
    logic                wr_set, rd_mem_en, look, rst_state, rsp_load, incr_evict_way_buf;
    logic                hit, victim_from_ptr;
    llc_pkg::line_t      rd_lines [WAYS];
    llc_pkg::line_t      lines_buf [WAYS];
    logic [TAG_BITS-1:0] rd_tags [WAYS];
    logic [TAG_BITS-1:0] tags_buf [WAYS];
    llc_pkg::llc_state_t rd_states [WAYS];
    llc_pkg::llc_state_t states_buf [WAYS];
    logic                rd_dirty [WAYS];
    logic                dirty_bits_buf [WAYS];
    logic                wr_en_lines_buf, wr_en_tags_buf, wr_en_states_buf, wr_en_dirty_bits_buf;
    llc_pkg::line_t      lines_buf_wr_data;
    logic [TAG_BITS-1:0] tags_buf_wr_data;
    llc_pkg::llc_state_t states_buf_wr_data;
    logic                dirty_bits_buf_wr_data;

    llc_set_mem #(.WAYS(WAYS), .SET_BITS(SET_BITS)) i_mem (
        .lines_in     (lines_buf),
        .tags_in      (tags_buf),
        .states_in    (states_buf),
        .dirty_in     (dirty_bits_buf),
        .evict_way_in (evict_way_buf),
        .*
    );

    llc_set_bufs #(.WAYS(WAYS), .SET_BITS(SET_BITS)) i_bufs (.*);

    llc_lookup #(.WAYS(WAYS), .SET_BITS(SET_BITS)) i_lookup (.*);

    llc_ctrl #(.WAYS(WAYS), .SET_BITS(SET_BITS)) i_ctrl (.*);

endmodule

`default_nettype wire
